// ==== common/kotku_pkg.sv ====
// Shared types and constants for the I/O side of the SoC
// Windows are {tga, adr[19:1]} compares, so byte bit 0 never takes part
// Sizes assume a single clock domain and one 16-bit Wishbone master

package kotku_pkg;

  // Master to slave request
  typedef struct packed {
    logic [19:1] adr;   // Word address
    logic        tga;   // 1 = I/O space
    logic [15:0] dat;
    logic [1:0]  sel;   // Byte lanes
    logic        we;
    logic        stb;
    logic        cyc;
  } wb_req_t;

  // Slave to master response
  typedef struct packed {
    logic [15:0] dat;
    logic        ack;
  } wb_rsp_t;

  // Decoded I/O targets
  typedef enum logic [1:0] {
    SLV_NONE,
    SLV_POST,
    SLV_GPIO,
    SLV_TIMER
  } io_slave_e;

  // One digit, segments g..a
  typedef logic [6:0] seg7_t;

  // I/O windows as {tga, adr[19:1]}
  // Masks look at tga and byte address bits 15:2
  localparam logic [19:0] POST_BASE  = 20'h80040;  // io 0x80
  localparam logic [19:0] POST_MASK  = 20'h87FFE;
  localparam logic [19:0] GPIO_BASE  = 20'h87880;  // io 0xf100 - 0xf103
  localparam logic [19:0] GPIO_MASK  = 20'h87FFE;
  localparam logic [19:0] TIMER_BASE = 20'h80020;  // io 0x40 - 0x43
  localparam logic [19:0] TIMER_MASK = 20'h87FFE;

  // Reset stretch after rst_lck goes high
  localparam int RST_HOLD_CYCLES = 8;
  localparam int RST_CNT_W       = $clog2(RST_HOLD_CYCLES + 1);

  // Interrupt lines, 0 = tick, 1 = button
  localparam int INT_LINES       = 2;
  localparam int INT_ID_W        = (INT_LINES > 1) ? $clog2(INT_LINES) : 1;
  localparam int INT_VECTOR_BASE = 8;

  // Pushbutton synchronizer depth, at least 2
  localparam int BTN_SYNC_STAGES = 2;

endpackage

// ==== verilog/sys_reset.sv ====
// Power-on reset from the active-low rst_lck input
// rst_o releases RST_HOLD_CYCLES + 2 clocks after rst_lck is first seen high
`timescale 1ns/1ps

module sys_reset (
  input  logic clk,
  input  logic rst_lck,
  output logic rst_o
);

  logic [1:0]                     sync_q;
  logic [kotku_pkg::RST_CNT_W-1:0] hold_q;

  // Two-flop synchronizer for the raw reset line
  always_ff @(posedge clk) begin
    sync_q <= {sync_q[0], rst_lck};
  end

  always_ff @(posedge clk) begin
    if (!sync_q[1]) begin
      hold_q <= kotku_pkg::RST_CNT_W'(kotku_pkg::RST_HOLD_CYCLES);
    end else if (hold_q != '0) begin
      hold_q <= hold_q - 1'b1;
    end
  end

  // Registered so the release is glitch free
  always_ff @(posedge clk) begin
    rst_o <= !sync_q[1] || (hold_q != '0);
  end

endmodule

// ==== verilog/io_decoder.sv ====
// I/O address decoder, purely combinational on the bus path
// Unmapped addresses get no ack, the master must not issue them
`timescale 1ns/1ps

module io_decoder (
  input  logic               clk,
  input  logic               rst_i,
  input  kotku_pkg::wb_req_t cpu_req_i,
  output kotku_pkg::wb_rsp_t bus_rsp_o,
  output kotku_pkg::wb_req_t post_req_o,
  output kotku_pkg::wb_req_t gpio_req_o,
  output kotku_pkg::wb_req_t timer_req_o,
  input  kotku_pkg::wb_rsp_t post_rsp_i,
  input  kotku_pkg::wb_rsp_t gpio_rsp_i,
  input  kotku_pkg::wb_rsp_t timer_rsp_i
);

  logic [19:0]          io_adr;
  kotku_pkg::io_slave_e slv;

  assign io_adr = {cpu_req_i.tga, cpu_req_i.adr};

  // Window match, first hit wins
  always_comb begin
    slv = kotku_pkg::SLV_NONE;
    if ((io_adr & kotku_pkg::POST_MASK) == kotku_pkg::POST_BASE) begin
      slv = kotku_pkg::SLV_POST;
    end else if ((io_adr & kotku_pkg::GPIO_MASK) == kotku_pkg::GPIO_BASE) begin
      slv = kotku_pkg::SLV_GPIO;
    end else if ((io_adr & kotku_pkg::TIMER_MASK) == kotku_pkg::TIMER_BASE) begin
      slv = kotku_pkg::SLV_TIMER;
    end
  end

  // Everyone sees the payload, only the target sees stb/cyc
  always_comb begin
    post_req_o      = cpu_req_i;
    gpio_req_o      = cpu_req_i;
    timer_req_o     = cpu_req_i;
    post_req_o.stb  = cpu_req_i.stb && (slv == kotku_pkg::SLV_POST);
    post_req_o.cyc  = cpu_req_i.cyc && (slv == kotku_pkg::SLV_POST);
    gpio_req_o.stb  = cpu_req_i.stb && (slv == kotku_pkg::SLV_GPIO);
    gpio_req_o.cyc  = cpu_req_i.cyc && (slv == kotku_pkg::SLV_GPIO);
    timer_req_o.stb = cpu_req_i.stb && (slv == kotku_pkg::SLV_TIMER);
    timer_req_o.cyc = cpu_req_i.cyc && (slv == kotku_pkg::SLV_TIMER);
  end

  // Response return path
  always_comb begin
    case (slv)
      kotku_pkg::SLV_POST:  bus_rsp_o = post_rsp_i;
      kotku_pkg::SLV_GPIO:  bus_rsp_o = gpio_rsp_i;
      kotku_pkg::SLV_TIMER: bus_rsp_o = timer_rsp_i;
      default:              bus_rsp_o = '0;   // No ack
    endcase
  end

  // Only one slave answers at any time
  a_one_slave: assert property (@(posedge clk) disable iff (rst_i)
    $onehot0({post_rsp_i.ack, gpio_rsp_i.ack, timer_rsp_i.ack}));

  // An ack must land inside the master's strobe
  a_ack_in_stb: assert property (@(posedge clk) disable iff (rst_i)
    bus_rsp_o.ack |-> cpu_req_i.stb);

endmodule

// ==== verilog/tick_timer.sv ====
// Periodic tick source, one 16-bit reload register at io 0x40
// Reload R != 0 gives a tick every R+1 clocks, reload 0 stops the timer
`timescale 1ns/1ps

module tick_timer (
  input  logic               clk,
  input  logic               rst_i,
  input  kotku_pkg::wb_req_t bus_req_i,
  output kotku_pkg::wb_rsp_t bus_rsp_o,
  output logic               tick_o
);

  logic        ack_q;
  logic        wr;
  logic [15:0] reload_q;
  logic [15:0] cnt_q;

  // New access seen this cycle
  assign wr = bus_req_i.stb && bus_req_i.cyc && bus_req_i.we && !ack_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_req_i.stb && bus_req_i.cyc && !ack_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      reload_q <= '0;
      cnt_q    <= '0;
      tick_o   <= 1'b0;
    end else if (wr) begin
      reload_q <= bus_req_i.dat;   // Whole word, restarts the count
      cnt_q    <= bus_req_i.dat;
      tick_o   <= 1'b0;
    end else if (reload_q != '0) begin
      if (cnt_q == '0) begin
        cnt_q  <= reload_q;
        tick_o <= 1'b1;
      end else begin
        cnt_q  <= cnt_q - 1'b1;
        tick_o <= 1'b0;
      end
    end else begin
      cnt_q  <= '0;            // Stopped
      tick_o <= 1'b0;
    end
  end

  assign bus_rsp_o = '{dat: reload_q, ack: ack_q};

  // A stopped timer stays quiet
  a_no_tick_stopped: assert property (@(posedge clk) disable iff (rst_i)
    tick_o |-> (reload_q != '0));

endmodule

// ==== verilog/gpio_port.sv ====
// Switches at io 0xf100 (read only), LEDs at io 0xf102 with byte lanes
// Pushbutton is active low, one press_o pulse per falling edge
`timescale 1ns/1ps

module gpio_port (
  input  logic               clk,
  input  logic               rst_i,
  input  kotku_pkg::wb_req_t bus_req_i,
  output kotku_pkg::wb_rsp_t bus_rsp_o,
  input  logic [7:0]         sw_i,
  input  logic               btn_n_i,
  output logic [15:0]        led_o,
  output logic               press_o
);

  logic                                  ack_q;
  logic                                  led_wr;
  logic [kotku_pkg::BTN_SYNC_STAGES-1:0] btn_sync_q;
  logic                                  btn_last_q;

  // Word 1 holds the LEDs
  assign led_wr = bus_req_i.stb && bus_req_i.cyc && bus_req_i.we && !ack_q
                  && bus_req_i.adr[1];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      led_o <= '0;
    end else begin
      ack_q <= bus_req_i.stb && bus_req_i.cyc && !ack_q;
      if (led_wr && bus_req_i.sel[0]) led_o[7:0]  <= bus_req_i.dat[7:0];
      if (led_wr && bus_req_i.sel[1]) led_o[15:8] <= bus_req_i.dat[15:8];
    end
  end

  assign bus_rsp_o = '{dat: bus_req_i.adr[1] ? led_o : {8'h00, sw_i}, ack: ack_q};

  // Button synchronizer and falling edge detect, idle level is high
  always_ff @(posedge clk) begin
    if (rst_i) begin
      btn_sync_q <= '1;
      btn_last_q <= 1'b1;
      press_o    <= 1'b0;
    end else begin
      btn_sync_q <= {btn_sync_q[kotku_pkg::BTN_SYNC_STAGES-2:0], btn_n_i};
      btn_last_q <= btn_sync_q[kotku_pkg::BTN_SYNC_STAGES-1];
      press_o    <= btn_last_q && !btn_sync_q[kotku_pkg::BTN_SYNC_STAGES-1];
    end
  end

endmodule

// ==== verilog/post_display.sv ====
// BIOS post-code port at io 0x80, low byte lane only
// Digits are active low as on the board
`timescale 1ns/1ps

module post_display (
  input  logic               clk,
  input  logic               rst_i,
  input  kotku_pkg::wb_req_t bus_req_i,
  output kotku_pkg::wb_rsp_t bus_rsp_o,
  output kotku_pkg::seg7_t   seg_hi_o,
  output kotku_pkg::seg7_t   seg_lo_o
);

  logic       ack_q;
  logic [7:0] code_q;

  // Hex digit to segments g..a, active high
  function automatic kotku_pkg::seg7_t hex_seg(input logic [3:0] nib);
    case (nib)
      4'h0: hex_seg = 7'h3F;
      4'h1: hex_seg = 7'h06;
      4'h2: hex_seg = 7'h5B;
      4'h3: hex_seg = 7'h4F;
      4'h4: hex_seg = 7'h66;
      4'h5: hex_seg = 7'h6D;
      4'h6: hex_seg = 7'h7D;
      4'h7: hex_seg = 7'h07;
      4'h8: hex_seg = 7'h7F;
      4'h9: hex_seg = 7'h6F;
      4'hA: hex_seg = 7'h77;
      4'hB: hex_seg = 7'h7C;   // Lower case b
      4'hC: hex_seg = 7'h39;
      4'hD: hex_seg = 7'h5E;   // Lower case d
      4'hE: hex_seg = 7'h79;
      default: hex_seg = 7'h71;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q  <= 1'b0;
      code_q <= '0;
    end else begin
      ack_q <= bus_req_i.stb && bus_req_i.cyc && !ack_q;
      if (bus_req_i.stb && bus_req_i.cyc && bus_req_i.we && !ack_q && bus_req_i.sel[0]) begin
        code_q <= bus_req_i.dat[7:0];
      end
    end
  end

  assign bus_rsp_o = '{dat: {8'h00, code_q}, ack: ack_q};

  assign seg_hi_o = ~hex_seg(code_q[7:4]);
  assign seg_lo_o = ~hex_seg(code_q[3:0]);

endmodule

// ==== verilog/int_ctrl.sv ====
// Interrupt controller, lowest pending line wins
// Vector replaces read data while inta_i is high, line clears when inta_i falls
`timescale 1ns/1ps

module int_ctrl (
  input  logic                           clk,
  input  logic                           rst_i,
  input  logic [kotku_pkg::INT_LINES-1:0] irq_i,
  input  logic                           inta_i,
  input  kotku_pkg::wb_rsp_t             bus_rsp_i,
  output kotku_pkg::wb_rsp_t             cpu_rsp_o,
  output logic                           intr_o
);

  logic [kotku_pkg::INT_LINES-1:0] pending_q;
  logic [kotku_pkg::INT_LINES-1:0] clr;
  logic [kotku_pkg::INT_ID_W-1:0]  lowest;
  logic [kotku_pkg::INT_ID_W-1:0]  line_c;
  logic [kotku_pkg::INT_ID_W-1:0]  line_q;
  logic                            inta_q;

  // Priority pick, scan from the top so the lowest line is last
  always_comb begin
    lowest = '0;
    for (int i = kotku_pkg::INT_LINES - 1; i >= 0; i--) begin
      if (pending_q[i]) lowest = kotku_pkg::INT_ID_W'(i);
    end
  end

  // Frozen once the acknowledge has started
  assign line_c = inta_q ? line_q : lowest;

  always_comb begin
    clr = '0;
    if (inta_q && !inta_i) clr[line_c] = 1'b1;   // Falling inta
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pending_q <= '0;
      line_q    <= '0;
      inta_q    <= 1'b0;
    end else begin
      pending_q <= (pending_q & ~clr) | irq_i;   // New request wins
      line_q    <= line_c;
      inta_q    <= inta_i;
    end
  end

  assign intr_o        = |pending_q;
  assign cpu_rsp_o.ack = bus_rsp_i.ack;
  assign cpu_rsp_o.dat = inta_i ? 16'(kotku_pkg::INT_VECTOR_BASE) + 16'(line_c)
                                : bus_rsp_i.dat;

  // An acknowledge cycle only starts on a raised request
  a_inta_needs_intr: assert property (@(posedge clk) disable iff (rst_i)
    $rose(inta_i) |-> intr_o);

  // intr_o only drops after an acknowledge ends
  a_drop_after_ack: assert property (@(posedge clk) disable iff (rst_i)
    $fell(intr_o) |-> $past(inta_q && !inta_i));

endmodule

// ==== verilog/kotku_io.sv ====
// I/O subsystem top, driven by a 16-bit Wishbone master on cpu_req_i
// Single clock, single transfers, rst_lck is active low
`timescale 1ns/1ps

module kotku_io (
  input  logic               clk,
  input  logic               rst_lck,
  input  kotku_pkg::wb_req_t cpu_req_i,
  output kotku_pkg::wb_rsp_t cpu_rsp_o,
  input  logic               inta_i,
  output logic               intr_o,
  input  logic [7:0]         sw_i,
  input  logic               btn_n_i,
  output logic [15:0]        led_o,
  output kotku_pkg::seg7_t   seg_hi_o,
  output kotku_pkg::seg7_t   seg_lo_o
);

  logic                            rst;
  logic                            tick;
  logic                            press;
  kotku_pkg::wb_rsp_t              bus_rsp;
  kotku_pkg::wb_req_t              post_req;
  kotku_pkg::wb_req_t              gpio_req;
  kotku_pkg::wb_req_t              timer_req;
  kotku_pkg::wb_rsp_t              post_rsp;
  kotku_pkg::wb_rsp_t              gpio_rsp;
  kotku_pkg::wb_rsp_t              timer_rsp;

  sys_reset u_reset (.clk(clk), .rst_lck(rst_lck), .rst_o(rst));

  io_decoder u_decoder (
    .clk         (clk),
    .rst_i       (rst),
    .cpu_req_i   (cpu_req_i),
    .bus_rsp_o   (bus_rsp),
    .post_req_o  (post_req),
    .gpio_req_o  (gpio_req),
    .timer_req_o (timer_req),
    .post_rsp_i  (post_rsp),
    .gpio_rsp_i  (gpio_rsp),
    .timer_rsp_i (timer_rsp)
  );

  post_display u_post (.clk(clk), .rst_i(rst), .bus_req_i(post_req), .bus_rsp_o(post_rsp),
                       .seg_hi_o(seg_hi_o), .seg_lo_o(seg_lo_o));

  gpio_port u_gpio (.clk(clk), .rst_i(rst), .bus_req_i(gpio_req), .bus_rsp_o(gpio_rsp),
                    .sw_i(sw_i), .btn_n_i(btn_n_i), .led_o(led_o), .press_o(press));

  tick_timer u_timer (.clk(clk), .rst_i(rst), .bus_req_i(timer_req),
                      .bus_rsp_o(timer_rsp), .tick_o(tick));

  // Line 0 timer tick, line 1 pushbutton
  int_ctrl u_pic (
    .clk       (clk),
    .rst_i     (rst),
    .irq_i     ({press, tick}),
    .inta_i    (inta_i),
    .bus_rsp_i (bus_rsp),
    .cpu_rsp_o (cpu_rsp_o),
    .intr_o    (intr_o)
  );

endmodule

// ==== tb/tb_kotku_checks.svh ====
// Bus cycles, typed compares and the seven-segment reference for tb_kotku_io
// Expects clk, cpu_req, cpu_rsp, err_cnt and miss_cnt in the including module
// Every task is entered and left on a falling clock edge

`ifndef TB_KOTKU_CHECKS_SVH
`define TB_KOTKU_CHECKS_SVH

// Hex digit to segments g..a, active high, as on the datasheet
function automatic kotku_pkg::seg7_t seg_ref(input logic [3:0] nib);
  case (nib)
    4'h0: seg_ref = 7'b0111111;
    4'h1: seg_ref = 7'b0000110;
    4'h2: seg_ref = 7'b1011011;
    4'h3: seg_ref = 7'b1001111;
    4'h4: seg_ref = 7'b1100110;
    4'h5: seg_ref = 7'b1101101;
    4'h6: seg_ref = 7'b1111101;
    4'h7: seg_ref = 7'b0000111;
    4'h8: seg_ref = 7'b1111111;
    4'h9: seg_ref = 7'b1101111;
    4'hA: seg_ref = 7'b1110111;
    4'hB: seg_ref = 7'b1111100;   // b
    4'hC: seg_ref = 7'b0111001;
    4'hD: seg_ref = 7'b1011110;   // d
    4'hE: seg_ref = 7'b1111001;
    default: seg_ref = 7'b1110001;
  endcase
endfunction

// Single I/O access, held until ack
task automatic bus_access(input logic we, input logic [15:0] io_adr, input logic [1:0] sel,
                          input logic [15:0] dat, output kotku_pkg::wb_rsp_t rsp);
  int waited;
  waited      = 0;
  rsp         = '0;
  cpu_req     = '0;
  cpu_req.adr = {4'h0, io_adr[15:1]};
  cpu_req.tga = 1'b1;
  cpu_req.dat = dat;
  cpu_req.sel = sel;
  cpu_req.we  = we;
  cpu_req.stb = 1'b1;
  cpu_req.cyc = 1'b1;
  @(negedge clk);
  while (!cpu_rsp.ack && waited < 8) begin
    waited++;
    @(negedge clk);
  end
  if (cpu_rsp.ack) begin
    rsp = cpu_rsp;   // Read data valid in the ack cycle
  end else begin
    miss_cnt++;
    $display("No acknowledge from io address %h within %0d cycles, time %0t",
             io_adr, waited, $time);
  end
  @(negedge clk);   // Strobe spans the edge that closes the ack cycle
  cpu_req = '0;
endtask

task automatic bus_write(input logic [15:0] io_adr, input logic [1:0] sel,
                         input logic [15:0] dat);
  kotku_pkg::wb_rsp_t rsp;
  bus_access(1'b1, io_adr, sel, dat, rsp);
endtask

task automatic bus_read(input logic [15:0] io_adr, output kotku_pkg::wb_rsp_t rsp);
  bus_access(1'b0, io_adr, 2'b11, 16'h0000, rsp);
endtask

task automatic check_rsp(input kotku_pkg::wb_rsp_t got, input kotku_pkg::wb_rsp_t exp,
                         input string what);
  if (got !== exp) begin
    err_cnt++;
    $display("CHECK FAILED at %0t: %s gave dat %h ack %b, expected dat %h ack %b",
             $time, what, got.dat, got.ack, exp.dat, exp.ack);
  end
endtask

task automatic check_seg(input kotku_pkg::seg7_t got, input kotku_pkg::seg7_t exp,
                         input string what);
  if (got !== exp) begin
    err_cnt++;
    $display("CHECK FAILED at %0t: %s shows %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic check_led(input logic [15:0] got, input logic [15:0] exp);
  if (got !== exp) begin
    err_cnt++;
    $display("CHECK FAILED at %0t: led_o is %h, expected %h", $time, got, exp);
  end
endtask

task automatic check_intr(input logic got, input logic exp);
  if (got !== exp) begin
    err_cnt++;
    $display("CHECK FAILED at %0t: intr_o is %b, expected %b", $time, got, exp);
  end
endtask

`endif

// ==== tb/tb_kotku_io.sv ====
// Testbench for kotku_io, plays the CPU on the Wishbone port and the INTA line
// Stimulus comes from a table built at time 0 from a fixed seed
`timescale 1ns/1ps

module tb_kotku_io;

  typedef enum logic [3:0] {
    OP_WRITE,     // Bus write
    OP_READ,      // Bus read, compare with exp
    OP_SWITCH,    // Drive sw_i from dat
    OP_PRESS,     // Hold btn_n_i low for dat cycles
    OP_IRQWAIT,   // Wait up to exp cycles for intr_o
    OP_INTA,      // Acknowledge, vector must equal exp
    OP_INTR,      // intr_o must equal exp[0]
    OP_LEDS,      // led_o must equal exp
    OP_SEGS       // Digits must show exp[7:0]
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [15:0] adr;
    logic [1:0]  sel;
    logic [15:0] dat;
    logic [15:0] exp;
  } step_t;

  logic               clk = 1'b0;
  logic               rst_lck;
  kotku_pkg::wb_req_t cpu_req;
  kotku_pkg::wb_rsp_t cpu_rsp;
  logic               inta;
  logic               intr;
  logic [7:0]         sw;
  logic               btn_n;
  logic [15:0]        led;
  kotku_pkg::seg7_t   seg_hi;
  kotku_pkg::seg7_t   seg_lo;

  step_t steps[$];
  int    err_cnt     = 0;
  int    miss_cnt    = 0;
  int    cycles      = 0;
  int    cycle_limit = 0;

  `include "tb_kotku_checks.svh"

  kotku_io u_dut (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .cpu_req_i (cpu_req),
    .cpu_rsp_o (cpu_rsp),
    .inta_i    (inta),
    .intr_o    (intr),
    .sw_i      (sw),
    .btn_n_i   (btn_n),
    .led_o     (led),
    .seg_hi_o  (seg_hi),
    .seg_lo_o  (seg_lo)
  );

  always #2 clk = ~clk;

  function automatic void add_step(input op_e op, input logic [15:0] adr,
                                   input logic [1:0] sel, input logic [15:0] dat,
                                   input logic [15:0] exp);
    steps.push_back('{op, adr, sel, dat, exp});
  endfunction

  task automatic build_table();
    logic [7:0]  post;
    logic [7:0]  sw_val;
    logic [15:0] led_exp;
    logic [15:0] dat;
    logic [15:0] r;
    logic [1:0]  sel;
    post    = 8'($urandom);
    sw_val  = 8'($urandom);
    led_exp = 16'h0000;
    r       = 16'(3 + ($urandom % 8));
    add_step(OP_LEDS, 16'h0000, 2'b00, 16'h0000, 16'h0000);   // Reset state
    add_step(OP_SEGS, 16'h0000, 2'b00, 16'h0000, 16'h0000);
    add_step(OP_INTR, 16'h0000, 2'b00, 16'h0000, 16'h0000);
    add_step(OP_WRITE, 16'h0080, 2'b01, {8'($urandom), post}, 16'h0000);
    add_step(OP_SEGS, 16'h0000, 2'b00, 16'h0000, {8'h00, post});
    add_step(OP_READ, 16'h0080, 2'b11, 16'h0000, {8'h00, post});
    add_step(OP_SWITCH, 16'h0000, 2'b00, {8'h00, sw_val}, 16'h0000);
    add_step(OP_READ, 16'hF100, 2'b11, 16'h0000, {8'h00, sw_val});
    for (int k = 0; k < 4; k++) begin
      sel = 2'(k);
      dat = 16'($urandom);
      if (sel[0]) led_exp[7:0] = dat[7:0];
      if (sel[1]) led_exp[15:8] = dat[15:8];
      add_step(OP_WRITE, 16'hF102, sel, dat, 16'h0000);
      add_step(OP_LEDS, 16'h0000, 2'b00, 16'h0000, led_exp);
      add_step(OP_READ, 16'hF102, 2'b11, 16'h0000, led_exp);
    end
    // Timer tick on line 0
    add_step(OP_WRITE, 16'h0040, 2'b11, r, 16'h0000);
    add_step(OP_READ, 16'h0040, 2'b11, 16'h0000, r);
    add_step(OP_IRQWAIT, 16'h0000, 2'b00, 16'h0000, 16'(2 * (r + 1) + 2));
    add_step(OP_WRITE, 16'h0040, 2'b11, 16'h0000, 16'h0000);
    add_step(OP_INTA, 16'h0000, 2'b00, 16'h0000, 16'(kotku_pkg::INT_VECTOR_BASE));
    add_step(OP_INTR, 16'h0000, 2'b00, 16'h0000, 16'h0000);
    // Button on line 1, 2 low cycles plus 6 of waiting
    add_step(OP_PRESS, 16'h0000, 2'b00, 16'h0002, 16'h0000);
    add_step(OP_IRQWAIT, 16'h0000, 2'b00, 16'h0000, 16'h0006);
    add_step(OP_INTA, 16'h0000, 2'b00, 16'h0000, 16'(kotku_pkg::INT_VECTOR_BASE + 1));
    add_step(OP_INTR, 16'h0000, 2'b00, 16'h0000, 16'h0000);
    // Both lines pending, lowest goes first
    add_step(OP_WRITE, 16'h0040, 2'b11, 16'h0002, 16'h0000);
    add_step(OP_PRESS, 16'h0000, 2'b00, 16'h0004, 16'h0000);
    add_step(OP_IRQWAIT, 16'h0000, 2'b00, 16'h0000, 16'h0008);
    add_step(OP_WRITE, 16'h0040, 2'b11, 16'h0000, 16'h0000);
    add_step(OP_INTA, 16'h0000, 2'b00, 16'h0000, 16'(kotku_pkg::INT_VECTOR_BASE));
    add_step(OP_INTR, 16'h0000, 2'b00, 16'h0000, 16'h0001);
    add_step(OP_INTA, 16'h0000, 2'b00, 16'h0000, 16'(kotku_pkg::INT_VECTOR_BASE + 1));
    add_step(OP_INTR, 16'h0000, 2'b00, 16'h0000, 16'h0000);
  endtask

  task automatic press_button(input logic [15:0] low_cycles);
    btn_n = 1'b0;
    repeat (low_cycles) @(negedge clk);
    btn_n = 1'b1;
  endtask

  task automatic wait_intr(input logic [15:0] limit);
    int n;
    n = 0;
    while (!intr && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!intr) begin
      miss_cnt++;
      $display("No interrupt request within %0d cycles, time %0t", limit, $time);
    end
  endtask

  task automatic int_ack(input logic [15:0] vec);
    kotku_pkg::wb_rsp_t want;
    want = '{dat: vec, ack: 1'b0};
    inta = 1'b1;
    @(negedge clk);
    check_rsp(cpu_rsp, want, "interrupt vector");
    inta = 1'b0;
    @(negedge clk);   // Chosen line cleared by now
  endtask

  task automatic run_step(input step_t s);
    kotku_pkg::wb_rsp_t rsp;
    kotku_pkg::wb_rsp_t want;
    case (s.op)
      OP_WRITE:   bus_write(s.adr, s.sel, s.dat);
      OP_READ: begin
        bus_read(s.adr, rsp);
        want = '{dat: s.exp, ack: 1'b1};
        check_rsp(rsp, want, $sformatf("read of io %h", s.adr));
      end
      OP_SWITCH:  sw = s.dat[7:0];
      OP_PRESS:   press_button(s.dat);
      OP_IRQWAIT: wait_intr(s.exp);
      OP_INTA:    int_ack(s.exp);
      OP_INTR:    check_intr(intr, s.exp[0]);
      OP_LEDS:    check_led(led, s.exp);
      OP_SEGS: begin
        check_seg(seg_hi, ~seg_ref(s.exp[7:4]), "high digit");   // Board is active low
        check_seg(seg_lo, ~seg_ref(s.exp[3:0]), "low digit");
      end
      default: begin
        miss_cnt++;
        $display("Unknown table operation at time %0t", $time);
      end
    endcase
  endtask

  // Watchdog sized from the table
  initial begin
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run did not finish within %0d cycles", cycle_limit);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    rst_lck = 1'b0;
    cpu_req = '0;
    inta    = 1'b0;
    sw      = 8'h00;
    btn_n   = 1'b1;
    void'($urandom(57211));
    build_table();
    cycle_limit = 40 * steps.size();
    repeat (2) @(negedge clk);
    rst_lck = 1'b1;
    repeat (kotku_pkg::RST_HOLD_CYCLES + 4) @(negedge clk);
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    $display("Finished %0d steps: %0d value errors, %0d missing responses",
             steps.size(), err_cnt, miss_cnt);
    if (err_cnt == 0 && miss_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+tb
common/kotku_pkg.sv
verilog/sys_reset.sv
verilog/io_decoder.sv
verilog/tick_timer.sv
verilog/gpio_port.sv
verilog/post_display.sv
verilog/int_ctrl.sv
verilog/kotku_io.sv
tb/tb_kotku_io.sv
